// File: list.f
logic/rv_pkg.sv
logic/regfile.sv
logic/alu.sv
logic/cmp.sv
logic/decode_stage.sv
logic/ex_stage.sv
logic/result_stage.sv
logic/int_core.sv
tests/tb_int_core.sv

// File: logic/alu.sv
`timescale 1ns/1ns

module alu import rv_pkg::*; (
    input  alu_op_t aluop,
    input  word_t   a,
    input  word_t   b,
    output word_t   f
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (aluop)
            alu_add:  f = a + b;
            alu_sub:  f = a - b;
            alu_sll:  f = a << shamt;
            alu_slt:  f = {31'b0, $signed(a) < $signed(b)};
            alu_sltu: f = {31'b0, a < b};
            alu_xor:  f = a ^ b;
            alu_srl:  f = a >> shamt;
            alu_sra:  f = word_t'($signed(a) >>> shamt);
            alu_or:   f = a | b;
            alu_and:  f = a & b;
            default:  f = '0;
        endcase
    end

endmodule

// File: logic/cmp.sv
`timescale 1ns/1ns

module cmp import rv_pkg::*; (
    input  cmp_op_t cmpop,
    input  word_t   a,
    input  word_t   b,
    output logic    f
);

    always_comb begin
        case (cmpop)
            cmp_beq:  f = (a == b);
            cmp_bne:  f = (a != b);
            cmp_blt:  f = ($signed(a) < $signed(b));
            cmp_bge:  f = ($signed(a) >= $signed(b));
            cmp_bltu: f = (a < b);
            cmp_bgeu: f = (a >= b);
            default:  f = 1'b0;
        endcase
    end

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ns

module decode_stage import rv_pkg::*; #(
    parameter int IN_DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  word_t       in_inst,
    input  word_t       in_pc,
    output logic        in_credit,
    input  logic        stall,
    output reg_idx_t    rs1_idx,
    output reg_idx_t    rs2_idx,
    input  word_t       rs1_v,
    input  word_t       rs2_v,
    input  logic        wb_en,
    input  reg_idx_t    wb_idx,
    output logic        id_valid,
    output word_t       id_pc,
    output word_t       id_inst,
    output alu_op_t     id_alu_op,
    output cmp_op_t     id_cmp_op,
    output alu_m1_sel_t id_m1_sel,
    output alu_m2_sel_t id_m2_sel,
    output cmp_m_sel_t  id_cmp_sel,
    output word_t       id_i_imm,
    output word_t       id_s_imm,
    output word_t       id_b_imm,
    output word_t       id_u_imm,
    output word_t       id_rs1_v,
    output word_t       id_rs2_v,
    output reg_idx_t    id_rd,
    output logic        id_we,
    output logic        id_is_branch,
    output logic        id_illegal
);

    localparam int ptr_w = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int cnt_w = $clog2(IN_DEPTH + 1);

    word_t            fifo_inst [IN_DEPTH];
    word_t            fifo_pc   [IN_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    word_t       inst;
    word_t       pc;
    opcode_t     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    word_t       i_imm;
    word_t       s_imm;
    word_t       b_imm;
    word_t       u_imm;
    alu_op_t     dec_alu_op;
    cmp_op_t     dec_cmp_op;
    alu_m1_sel_t dec_m1_sel;
    alu_m2_sel_t dec_m2_sel;
    cmp_m_sel_t  dec_cmp_sel;
    reg_idx_t    dec_rs1;
    reg_idx_t    dec_rs2;
    reg_idx_t    dec_rd;
    logic        dec_we;
    logic        dec_is_branch;
    logic        dec_illegal;

    logic [31:0] busy;
    logic [31:0] busy_now;
    logic        hazard;
    logic        issue;

    function automatic logic [ptr_w-1:0] ptr_inc(logic [ptr_w-1:0] p);
        return (p == ptr_w'(IN_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (in_valid) begin
            fifo_inst[wr_ptr] <= in_inst;
            fifo_pc[wr_ptr]   <= in_pc;
        end
    end

    // no full check, fetch only sends with a credit in hand
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (issue) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + cnt_w'(in_valid) - cnt_w'(issue);
        end
    end

    assign inst   = fifo_inst[rd_ptr];
    assign pc     = fifo_pc[rd_ptr];
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign i_imm = {{21{inst[31]}}, inst[30:20]};
    assign s_imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
    assign b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'h000};

    always_comb begin
        dec_alu_op    = alu_add;
        dec_cmp_op    = cmp_beq;
        dec_m1_sel    = m1_rs1_v;
        dec_m2_sel    = m2_rs2_v;
        dec_cmp_sel   = cmp_m_rs2_v;
        dec_rs1       = '0;
        dec_rs2       = '0;
        dec_we        = 1'b0;
        dec_is_branch = 1'b0;
        dec_illegal   = 1'b0;
        case (opcode)
            op_reg: begin
                dec_alu_op  = {funct7[5], funct3};
                dec_cmp_op  = (funct3 == 3'b011) ? cmp_bltu : cmp_blt;
                dec_rs1     = inst[19:15];
                dec_rs2     = inst[24:20];
                dec_we      = 1'b1;
                dec_illegal = !(funct7 == 7'b0000000 ||
                                (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            op_imm: begin
                dec_alu_op  = {funct3 == 3'b101 && funct7[5], funct3};
                dec_cmp_op  = (funct3 == 3'b011) ? cmp_bltu : cmp_blt;
                dec_m2_sel  = m2_i_imm;
                dec_cmp_sel = cmp_m_i_imm;
                dec_rs1     = inst[19:15];
                dec_we      = 1'b1;
                if (funct3 == 3'b001) begin
                    dec_illegal = (funct7 != 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    dec_illegal = (funct7 != 7'b0000000 && funct7 != 7'b0100000);
                end
            end
            // rs1 index stays zero, so this is x0 + u_imm
            op_lui: begin
                dec_m2_sel = m2_u_imm;
                dec_we     = 1'b1;
            end
            op_auipc: begin
                dec_m1_sel = m1_pc;
                dec_m2_sel = m2_u_imm;
                dec_we     = 1'b1;
            end
            op_branch: begin
                dec_m1_sel    = m1_pc;
                dec_m2_sel    = m2_b_imm;
                dec_cmp_op    = funct3;
                dec_rs1       = inst[19:15];
                dec_rs2       = inst[24:20];
                dec_is_branch = 1'b1;
                dec_illegal   = (funct3[2:1] == 2'b01);
            end
            default: begin
                dec_illegal = 1'b1;
            end
        endcase
        // illegal entries retire as x0 + x0 with no write
        if (dec_illegal) begin
            dec_alu_op    = alu_add;
            dec_m1_sel    = m1_rs1_v;
            dec_m2_sel    = m2_rs2_v;
            dec_rs1       = '0;
            dec_rs2       = '0;
            dec_we        = 1'b0;
            dec_is_branch = 1'b0;
        end
        dec_we = dec_we && inst[11:7] != '0;
        dec_rd = dec_we ? inst[11:7] : '0;
    end

    assign rs1_idx = dec_rs1;
    assign rs2_idx = dec_rs2;

    // a register retiring this cycle is already readable through the regfile
    assign busy_now = wb_en ? (busy & ~(32'd1 << wb_idx)) : busy;

    // rd is checked too, an older write must not clear a younger writer's bit
    assign hazard    = busy_now[dec_rs1] | busy_now[dec_rs2] | busy_now[dec_rd];
    assign issue     = (count != '0) && !stall && !hazard;
    assign in_credit = issue;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= '0;
        end else if (issue && dec_we) begin
            busy <= busy_now | (32'd1 << dec_rd);
        end else begin
            busy <= busy_now;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (!stall) begin
            id_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_pc        <= pc;
            id_inst      <= inst;
            id_alu_op    <= dec_alu_op;
            id_cmp_op    <= dec_cmp_op;
            id_m1_sel    <= dec_m1_sel;
            id_m2_sel    <= dec_m2_sel;
            id_cmp_sel   <= dec_cmp_sel;
            id_i_imm     <= i_imm;
            id_s_imm     <= s_imm;
            id_b_imm     <= b_imm;
            id_u_imm     <= u_imm;
            id_rs1_v     <= rs1_v;
            id_rs2_v     <= rs2_v;
            id_rd        <= dec_rd;
            id_we        <= dec_we;
            id_is_branch <= dec_is_branch;
            id_illegal   <= dec_illegal;
        end
    end

endmodule

// File: logic/ex_stage.sv
`timescale 1ns/1ns

module ex_stage import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        id_valid,
    input  word_t       id_pc,
    input  word_t       id_inst,
    input  alu_op_t     id_alu_op,
    input  cmp_op_t     id_cmp_op,
    input  alu_m1_sel_t id_m1_sel,
    input  alu_m2_sel_t id_m2_sel,
    input  cmp_m_sel_t  id_cmp_sel,
    input  word_t       id_i_imm,
    input  word_t       id_s_imm,
    input  word_t       id_b_imm,
    input  word_t       id_u_imm,
    input  word_t       id_rs1_v,
    input  word_t       id_rs2_v,
    input  reg_idx_t    id_rd,
    input  logic        id_we,
    input  logic        id_is_branch,
    input  logic        id_illegal,
    output logic        ex_valid,
    output word_t       ex_pc,
    output reg_idx_t    ex_rd,
    output word_t       ex_alu_out,
    output logic        ex_br_en,
    output logic        ex_we,
    output logic        ex_is_branch,
    output logic        ex_illegal
);

    word_t alu_a;
    word_t alu_b;
    word_t cmp_b;
    word_t alu_f;
    logic  cmp_f;
    logic  is_slt;

    assign alu_a = (id_m1_sel == m1_pc) ? id_pc : id_rs1_v;
    assign cmp_b = (id_cmp_sel == cmp_m_i_imm) ? id_i_imm : id_rs2_v;

    always_comb begin
        case (id_m2_sel)
            m2_i_imm: alu_b = id_i_imm;
            m2_u_imm: alu_b = id_u_imm;
            m2_b_imm: alu_b = id_b_imm;
            m2_s_imm: alu_b = id_s_imm;
            m2_rs2_v: alu_b = id_rs2_v;
            default:  alu_b = '0;
        endcase
    end

    alu u_alu (
        .aluop (id_alu_op),
        .a     (alu_a),
        .b     (alu_b),
        .f     (alu_f)
    );

    cmp u_cmp (
        .cmpop (id_cmp_op),
        .a     (id_rs1_v),
        .b     (cmp_b),
        .f     (cmp_f)
    );

    // slt/sltu/slti/sltiu, funct3 01x in OP or OP-IMM
    assign is_slt = !id_illegal && (id_inst[6:0] == op_reg || id_inst[6:0] == op_imm) &&
                    id_inst[14:13] == 2'b01;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (!stall) begin
            ex_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_pc        <= id_pc;
            ex_rd        <= id_rd;
            ex_alu_out   <= is_slt ? {31'b0, cmp_f} : alu_f;
            ex_br_en     <= cmp_f;
            ex_we        <= id_we;
            ex_is_branch <= id_is_branch;
            ex_illegal   <= id_illegal;
        end
    end

endmodule

// File: logic/int_core.sv
`timescale 1ns/1ns

module int_core import rv_pkg::*; #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  word_t    in_inst,
    input  word_t    in_pc,
    output logic     in_credit,
    output logic     out_valid,
    output word_t    out_pc,
    output reg_idx_t out_rd,
    output word_t    out_value,
    output logic     out_br_taken,
    output logic     out_illegal,
    input  logic     out_credit
);

    // stage nets share the port names, so instances connect by name
    reg_idx_t    rs1_idx;
    reg_idx_t    rs2_idx;
    word_t       rs1_v;
    word_t       rs2_v;
    logic        stall;
    logic        wb_en;
    reg_idx_t    wb_idx;
    word_t       wb_data;

    logic        id_valid;
    word_t       id_pc;
    word_t       id_inst;
    alu_op_t     id_alu_op;
    cmp_op_t     id_cmp_op;
    alu_m1_sel_t id_m1_sel;
    alu_m2_sel_t id_m2_sel;
    cmp_m_sel_t  id_cmp_sel;
    word_t       id_i_imm;
    word_t       id_s_imm;
    word_t       id_b_imm;
    word_t       id_u_imm;
    word_t       id_rs1_v;
    word_t       id_rs2_v;
    reg_idx_t    id_rd;
    logic        id_we;
    logic        id_is_branch;
    logic        id_illegal;

    logic        ex_valid;
    word_t       ex_pc;
    reg_idx_t    ex_rd;
    word_t       ex_alu_out;
    logic        ex_br_en;
    logic        ex_we;
    logic        ex_is_branch;
    logic        ex_illegal;

    decode_stage #(.IN_DEPTH(IN_DEPTH)) u_decode (.*);

    regfile u_regfile (.*);

    ex_stage u_ex (.*);

    result_stage #(.OUT_CREDITS(OUT_CREDITS)) u_result (.*);

endmodule

// File: logic/regfile.sv
`timescale 1ns/1ns

module regfile import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    output word_t    rs1_v,
    output word_t    rs2_v,
    input  logic     wb_en,
    input  reg_idx_t wb_idx,
    input  word_t    wb_data
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_idx != '0) begin
            regs[wb_idx] <= wb_data;
        end
    end

    // write-through, x0 reads zero
    assign rs1_v = (rs1_idx == '0) ? '0 :
                   (wb_en && wb_idx == rs1_idx) ? wb_data : regs[rs1_idx];
    assign rs2_v = (rs2_idx == '0) ? '0 :
                   (wb_en && wb_idx == rs2_idx) ? wb_data : regs[rs2_idx];

endmodule

// File: logic/result_stage.sv
`timescale 1ns/1ns

module result_stage import rv_pkg::*; #(
    parameter int OUT_CREDITS = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ex_valid,
    input  word_t    ex_pc,
    input  reg_idx_t ex_rd,
    input  word_t    ex_alu_out,
    input  logic     ex_br_en,
    input  logic     ex_we,
    input  logic     ex_is_branch,
    input  logic     ex_illegal,
    output logic     stall,
    output logic     wb_en,
    output reg_idx_t wb_idx,
    output word_t    wb_data,
    output logic     out_valid,
    output word_t    out_pc,
    output word_t    out_value,
    output reg_idx_t out_rd,
    output logic     out_br_taken,
    output logic     out_illegal,
    input  logic     out_credit
);

    localparam int cnt_w = $clog2(OUT_CREDITS + 1);

    logic             rec_valid;
    logic             rec_we;
    logic [cnt_w-1:0] credits;

    // record leaves as soon as a credit is there
    assign out_valid = rec_valid && credits != '0;
    assign stall     = rec_valid && credits == '0;

    // writeback happens when the record is released
    assign wb_en   = out_valid && rec_we;
    assign wb_idx  = out_rd;
    assign wb_data = out_value;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rec_valid <= 1'b0;
            credits   <= cnt_w'(OUT_CREDITS);
        end else begin
            if (!stall) begin
                rec_valid <= ex_valid;
            end
            credits <= credits - cnt_w'(out_valid) + cnt_w'(out_credit);
        end
    end

    // decode already zeroes rd for entries that write no register
    always_ff @(posedge clk) begin
        if (!stall) begin
            out_pc       <= ex_pc;
            out_rd       <= ex_rd;
            out_value    <= ex_alu_out;
            out_br_taken <= ex_is_branch && ex_br_en;
            out_illegal  <= ex_illegal;
            rec_we       <= ex_we;
        end
    end

endmodule

// File: logic/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  cmp_op_t;
    typedef logic        alu_m1_sel_t;
    typedef logic [2:0]  alu_m2_sel_t;
    typedef logic        cmp_m_sel_t;

    // alu codes follow {funct7[5], funct3} of the OP encoding
    localparam alu_op_t alu_add  = 4'b0000;
    localparam alu_op_t alu_sll  = 4'b0001;
    localparam alu_op_t alu_slt  = 4'b0010;
    localparam alu_op_t alu_sltu = 4'b0011;
    localparam alu_op_t alu_xor  = 4'b0100;
    localparam alu_op_t alu_srl  = 4'b0101;
    localparam alu_op_t alu_or   = 4'b0110;
    localparam alu_op_t alu_and  = 4'b0111;
    localparam alu_op_t alu_sub  = 4'b1000;
    localparam alu_op_t alu_sra  = 4'b1101;

    // same values as the branch funct3
    localparam cmp_op_t cmp_beq  = 3'b000;
    localparam cmp_op_t cmp_bne  = 3'b001;
    localparam cmp_op_t cmp_blt  = 3'b100;
    localparam cmp_op_t cmp_bge  = 3'b101;
    localparam cmp_op_t cmp_bltu = 3'b110;
    localparam cmp_op_t cmp_bgeu = 3'b111;

    localparam alu_m1_sel_t m1_rs1_v = 1'b0;
    localparam alu_m1_sel_t m1_pc    = 1'b1;

    localparam alu_m2_sel_t m2_i_imm = 3'd0;
    localparam alu_m2_sel_t m2_u_imm = 3'd1;
    localparam alu_m2_sel_t m2_b_imm = 3'd2;
    localparam alu_m2_sel_t m2_s_imm = 3'd3;
    localparam alu_m2_sel_t m2_rs2_v = 3'd4;

    localparam cmp_m_sel_t cmp_m_rs2_v = 1'b0;
    localparam cmp_m_sel_t cmp_m_i_imm = 1'b1;

    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_branch = 7'b1100011;

endpackage

// File: tests/tb_int_core.sv
`timescale 1ns/1ns

module tb_int_core import rv_pkg::*; ();

    localparam int IN_DEPTH     = 4;
    localparam int OUT_CREDITS  = 2;
    localparam int RESET_CYCLES = 8;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        word_t    value;
        logic     br;
        logic     ill;
    } exp_t;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    word_t    in_inst;
    word_t    in_pc;
    logic     in_credit;
    logic     out_valid;
    word_t    out_pc;
    reg_idx_t out_rd;
    word_t    out_value;
    logic     out_br_taken;
    logic     out_illegal;
    logic     out_credit;

    word_t       shadow [32];
    exp_t        exp_q [$];
    logic [31:0] lfsr_state = 32'd36;
    word_t       next_pc = 32'h0000_1000;
    int          fetch_credits = IN_DEPTH;
    int          cycle = 0;
    int          sent_count = 0;
    int          rec_count = 0;
    int          sample_cycle = 0;
    int          last_out_cycle = 0;
    int          withheld = 0;
    logic        hold_credits = 1'b0;

    int_core #(.IN_DEPTH(IN_DEPTH), .OUT_CREDITS(OUT_CREDITS)) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_inst      (in_inst),
        .in_pc        (in_pc),
        .in_credit    (in_credit),
        .out_valid    (out_valid),
        .out_pc       (out_pc),
        .out_rd       (out_rd),
        .out_value    (out_value),
        .out_br_taken (out_br_taken),
        .out_illegal  (out_illegal),
        .out_credit   (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("sim failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic word_t rand_bits(int n);
        word_t r;
        logic  fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd);
        return {imm, rs1, f3, rd, op_imm};
    endfunction

    function automatic word_t enc_u(logic [6:0] opc, logic [19:0] imm, reg_idx_t rd);
        return {imm, rd, opc};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    // RV32I integer results with alt selecting sub and sra
    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return word_t'($signed(a) < $signed(b));
            3'd3: return word_t'(a < b);
            3'd4: return a ^ b;
            3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // builds the expected retire record and updates the shadow registers in program order
    function automatic exp_t model(word_t inst, word_t pc);
        exp_t       e;
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      a;
        word_t      b;
        word_t      imm;
        logic       wr;
        f3 = inst[14:12];
        f7 = inst[31:25];
        a = shadow[inst[19:15]];
        b = shadow[inst[24:20]];
        e = '0;
        e.pc = pc;
        wr = 1'b0;
        case (inst[6:0])
            op_reg: begin
                if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
                    e.value = alu_ref(f3, f7[5], a, b);
                    wr = 1'b1;
                end else begin
                    e.ill = 1'b1;
                end
            end
            op_imm: begin
                imm = {{20{inst[31]}}, inst[31:20]};
                if ((f3 == 3'd1 && f7 != 7'h00) ||
                    (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)) begin
                    e.ill = 1'b1;
                end else begin
                    e.value = alu_ref(f3, f3 == 3'd5 && f7[5], a, imm);
                    wr = 1'b1;
                end
            end
            op_lui: begin
                e.value = {inst[31:12], 12'h000};
                wr = 1'b1;
            end
            op_auipc: begin
                e.value = pc + {inst[31:12], 12'h000};
                wr = 1'b1;
            end
            op_branch: begin
                if (f3 == 3'd2 || f3 == 3'd3) begin
                    e.ill = 1'b1;
                end else begin
                    imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                    e.value = pc + imm;
                    e.br = branch_ref(f3, a, b);
                end
            end
            default: e.ill = 1'b1;
        endcase
        if (wr && inst[11:7] != 5'd0) begin
            shadow[inst[11:7]] = e.value;
            e.rd = inst[11:7];
        end
        return e;
    endfunction

    task automatic send(input word_t inst);
        @(negedge clk);
        in_valid = 1'b0;
        while (fetch_credits == 0) @(negedge clk);
        in_valid = 1'b1;
        in_inst = inst;
        in_pc = next_pc;
        fetch_credits--;
        sample_cycle = cycle + 1;
        exp_q.push_back(model(inst, next_pc));
        next_pc += 4;
        sent_count++;
    endtask

    task automatic drain();
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    function automatic reg_idx_t pick_reg();
        return reg_idx_t'(1 + rand_bits(3));
    endfunction

    task automatic test_alu();
        logic [2:0] f3;
        for (int r = 1; r <= 8; r++) begin
            send(enc_u(op_lui, 20'(rand_bits(20)), reg_idx_t'(r)));
            send(enc_i(12'(rand_bits(12)), reg_idx_t'(r), 3'd0, reg_idx_t'(r)));
        end
        repeat (2) begin
            for (int i = 0; i < 10; i++) begin
                f3 = (i < 8) ? 3'(i) : ((i == 8) ? 3'd0 : 3'd5);
                send(enc_r((i < 8) ? 7'h00 : 7'h20, pick_reg(), pick_reg(), f3,
                           reg_idx_t'(10 + i)));
            end
            // slli, srli and srai carry funct7 in the immediate
            for (int i = 0; i < 9; i++) begin
                f3 = (i < 8) ? 3'(i) : 3'd5;
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    send(enc_i({(i == 8) ? 7'h20 : 7'h00, 5'(rand_bits(5))}, pick_reg(), f3,
                               reg_idx_t'(20 + i)));
                end else begin
                    send(enc_i(12'(rand_bits(12)), pick_reg(), f3, reg_idx_t'(20 + i)));
                end
            end
        end
        drain();
    endtask

    task automatic test_chain();
        int first;
        first = rec_count;
        send(enc_i(12'h005, 5'd1, 3'd0, 5'd20));
        for (int i = 0; i < 6; i++) begin
            send(enc_r(7'h00, 5'd20, 5'd20, 3'd0, 5'd21));
            send(enc_r(7'h20, 5'd20, 5'd21, 3'd0, 5'd20));
            send(enc_i(12'(rand_bits(12)), 5'd20, 3'd4, 5'd20));
            send(enc_r(7'h00, 5'd21, 5'd20, 3'd1, 5'd22));
        end
        drain();
        check_value("chain_records", 25, rec_count - first);
    endtask

    task automatic test_branch();
        reg_idx_t   ra [5];
        reg_idx_t   rb [5];
        logic [2:0] conds [6];
        ra = '{5'd25, 5'd25, 5'd27, 5'd28, 5'd25};
        rb = '{5'd26, 5'd27, 5'd25, 5'd25, 5'd28};
        conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        send(enc_u(op_lui, {1'b0, 19'(rand_bits(19))}, 5'd25));
        send(enc_i(12'h123, 5'd25, 3'd0, 5'd25));
        send(enc_i(12'h000, 5'd25, 3'd0, 5'd26));
        send(enc_i(12'h064, 5'd25, 3'd0, 5'd27));
        send(enc_u(op_lui, 20'h80000, 5'd28));
        send(enc_i(12'(rand_bits(12)), 5'd28, 3'd6, 5'd28));
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 5; p++) begin
                send(enc_b({12'(rand_bits(12)), 1'b0}, rb[p], ra[p], conds[c]));
            end
        end
        repeat (4) send(enc_u(op_auipc, 20'(rand_bits(20)), 5'd29));
        drain();
    endtask

    task automatic test_illegal();
        send({12'h000, 5'd1, 3'd2, 5'd5, 7'b0000011});
        send(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd6));
        send(enc_b(13'h0010, 5'd2, 5'd1, 3'd2));
        send(enc_i(12'h000, 5'd5, 3'd0, 5'd30));
        send(enc_i(12'h000, 5'd6, 3'd0, 5'd31));
        send(enc_i(12'h07b, 5'd1, 3'd0, 5'd0));
        send(enc_u(op_lui, 20'habcde, 5'd0));
        send(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd31));
        send(enc_i(12'h001, 5'd0, 3'd0, 5'd30));
        send(32'h0000_0000);
        drain();
    endtask

    task automatic test_backpressure();
        int first;
        first = rec_count;
        hold_credits = 1'b1;
        for (int i = 0; i < 6; i++) begin
            send(enc_i(12'(rand_bits(12)), pick_reg(), 3'd0, reg_idx_t'(10 + i)));
        end
        @(negedge clk);
        in_valid = 1'b0;
        repeat (30) @(negedge clk);
        check_value("held_records", OUT_CREDITS, rec_count - first);
        hold_credits = 1'b0;
        drain();
        check_value("released_records", 6, rec_count - first);
    endtask

    task automatic test_credits();
        check_value("fetch_credits_idle", IN_DEPTH, fetch_credits);
        for (int i = 0; i < 8; i++) begin
            send(enc_r(7'h00, pick_reg(), pick_reg(), 3'd4, reg_idx_t'(12 + i)));
        end
        drain();
        check_value("fetch_credits_drained", IN_DEPTH, fetch_credits);
        send(enc_i(12'h3a5, 5'd2, 3'd7, 5'd9));
        drain();
        check_value("retire_latency", 3, last_out_cycle - sample_cycle);
    endtask

    // fetch side credit return and watchdog
    always @(posedge clk) begin
        cycle++;
        if (rst_n && in_credit) begin
            fetch_credits++;
            if (fetch_credits > IN_DEPTH) begin
                $display("fetch received more credits than buffer slots at %0t", $time);
                stop_with_failure();
            end
        end
        if (cycle > RESET_CYCLES + 40 * (sent_count + 1)) begin
            $display("timeout after %0d cycles with %0d records pending", cycle, exp_q.size());
            stop_with_failure();
        end
    end

    always @(negedge clk) begin : monitor
        exp_t e;
        logic give;
        if (rst_n) begin
            give = 1'b0;
            if (out_valid) begin
                rec_count++;
                last_out_cycle = cycle;
                if (exp_q.size() == 0) begin
                    $display("record for pc %h arrived with no instruction pending", out_pc);
                    stop_with_failure();
                end else begin
                    e = exp_q.pop_front();
                    check_value("out_pc", e.pc, out_pc);
                    check_value("out_rd", e.rd, out_rd);
                    check_value("out_value", e.value, out_value);
                    check_value("out_br_taken", e.br, out_br_taken);
                    check_value("out_illegal", e.ill, out_illegal);
                    if (hold_credits) begin
                        withheld++;
                    end else begin
                        give = 1'b1;
                    end
                end
            end
            // held credits go back one per cycle
            if (!give && !hold_credits && withheld > 0) begin
                withheld--;
                give = 1'b1;
            end
            out_credit = give;
        end
    end

    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_inst = '0;
        in_pc = '0;
        out_credit = 1'b0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_alu();
        test_chain();
        test_branch();
        test_illegal();
        test_backpressure();
        test_credits();
        $display("sim passed");
        $finish;
    end

endmodule
